// File: hw/axil2apb_pkg.sv
// AXI-lite to APB bridge shared widths, vector types, response codes and FSM states
package axil2apb_pkg;

////////////////////////////////////////////////////////////////////////////
// Bus geometry
////////////////////////////////////////////////////////////////////////////
	localparam int ADDR_W   = 32;
	localparam int DATA_W   = 32;
	localparam int STRB_W   = DATA_W / 8;
	// Byte offset bits inside one word
	localparam int ADDR_LSB = 2;
	localparam int PROT_W   = 3;

	// Full byte address, as seen on AXI and PADDR
	typedef logic [ADDR_W-1:0]          addr_t;
	// Word address, low ADDR_LSB bits stripped
	typedef logic [ADDR_W-ADDR_LSB-1:0] waddr_t;
	typedef logic [DATA_W-1:0]          data_t;
	typedef logic [STRB_W-1:0]          strb_t;
	typedef logic [PROT_W-1:0]          prot_t;
	typedef logic [1:0]                 resp_t;

	// Only two responses ever leave the bridge
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

////////////////////////////////////////////////////////////////////////////
// APB sequencer states
////////////////////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {S_IDLE, S_SETUP, S_ACCESS} apb_state_e;

endpackage

// File: hw/bridge_if.sv
// Internal bridge links: arbiter request into the APB sequencer, and its completion out
`timescale 1ns/1ps

// One pending AXI transfer offered to the sequencer
interface apb_req_if;
	logic                  valid;
	logic                  ready;
	logic                  write;
	axil2apb_pkg::waddr_t  addr;
	axil2apb_pkg::prot_t   prot;
	axil2apb_pkg::data_t   wdata;
	axil2apb_pkg::strb_t   wstrb;

	// Arbiter side
	modport source (output valid, write, addr, prot, wdata, wstrb, input ready);
	// Sequencer side, ready high only in idle
	modport sink   (input valid, write, addr, prot, wdata, wstrb, output ready);
endinterface

// Finished APB transfer plus the response slot flags
interface apb_done_if;
	logic                  done;
	logic                  write;
	axil2apb_pkg::data_t   rdata;
	logic                  error;
	// Output register empty or draining this cycle
	logic                  b_free;
	logic                  r_free;

	// Sequencer pulses done on the PREADY cycle
	modport source   (output done, write, rdata, error);
	// Response registers
	modport response (input done, write, rdata, error, output b_free, r_free);
	// Arbiter only looks at the slots
	modport arbiter  (input b_free, r_free);
endinterface

// File: hw/skid_buffer.sv
// Valid/ready skid buffer with a registered input ready for one AXI channel
`timescale 1ns/1ps

module skid_buffer #(
	parameter int WIDTH = 8
) (
	input  logic             S_AXI_ACLK,
	input  logic             S_AXI_ARESETN,
	// Upstream
	input  logic             i_valid,
	output logic             o_ready,
	input  logic [WIDTH-1:0] i_data,
	// Downstream
	output logic             o_valid,
	input  logic             i_ready,
	output logic [WIDTH-1:0] o_data
);

	// Spilled entry
	logic             r_valid;
	logic [WIDTH-1:0] r_data;

	// Accept only while the spill slot is empty
	assign o_ready = !r_valid;

	// Held entry goes first, else straight pass-through
	assign o_valid = r_valid || i_valid;
	assign o_data  = r_valid ? r_data : i_data;

	// Spill when input is taken but the output stalls
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Capture whatever sits on the input while there is room
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

endmodule

// File: hw/req_arbiter.sv
// Joins AW with W, alternates between read and write, and offers one APB request
`timescale 1ns/1ps

module req_arbiter (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	// Write address skid output
	input  logic                  i_aw_valid,
	output logic                  o_aw_ready,
	input  axil2apb_pkg::waddr_t  i_aw_addr,
	input  axil2apb_pkg::prot_t   i_aw_prot,
	// Write data skid output
	input  logic                  i_w_valid,
	output logic                  o_w_ready,
	input  axil2apb_pkg::data_t   i_w_data,
	input  axil2apb_pkg::strb_t   i_w_strb,
	// Read address skid output
	input  logic                  i_ar_valid,
	output logic                  o_ar_ready,
	input  axil2apb_pkg::waddr_t  i_ar_addr,
	input  axil2apb_pkg::prot_t   i_ar_prot,
	// Request out, slot flags in
	apb_req_if.source             req,
	apb_done_if.arbiter           done
);

	logic write_grant;
	logic can_write;
	logic can_read;
	logic pick_write;
	logic take;

	// Write needs both halves, and each kind needs a free response slot
	assign can_write = i_aw_valid && i_w_valid && done.b_free;
	assign can_read  = i_ar_valid && done.r_free;

	// Tie goes to whichever kind did not go last
	assign pick_write = can_write && (!can_read || write_grant);

	assign req.valid = can_write || can_read;
	assign req.write = pick_write;
	assign req.addr  = pick_write ? i_aw_addr : i_ar_addr;
	assign req.prot  = pick_write ? i_aw_prot : i_ar_prot;
	assign req.wdata = i_w_data;
	assign req.wstrb = i_w_strb;

	// Pop the skid buffers on the handshake
	assign take       = req.valid && req.ready;
	assign o_aw_ready = take && pick_write;
	assign o_w_ready  = take && pick_write;
	assign o_ar_ready = take && !pick_write;

	// Clear after a write, set after a read
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			write_grant <= 1'b0;
		else if (take)
			write_grant <= !pick_write;
	end

endmodule

// File: hw/apb_sequencer.sv
// APB master FSM: setup and access phases for one request at a time
`timescale 1ns/1ps

module apb_sequencer (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	apb_req_if.sink               req,
	apb_done_if.source            done,
	// APB master
	output logic                  o_psel,
	output logic                  o_penable,
	output axil2apb_pkg::addr_t   o_paddr,
	output logic                  o_pwrite,
	output axil2apb_pkg::data_t   o_pwdata,
	output axil2apb_pkg::strb_t   o_pwstrb,
	output axil2apb_pkg::prot_t   o_pprot,
	input  logic                  i_pready,
	input  axil2apb_pkg::data_t   i_prdata,
	input  logic                  i_pslverr
);

	axil2apb_pkg::apb_state_e state;
	axil2apb_pkg::apb_state_e state_nxt;

	// New request only accepted between transfers
	assign req.ready = (state == axil2apb_pkg::S_IDLE);

	always_comb
	begin
		state_nxt = state;
		unique case (state)
			axil2apb_pkg::S_IDLE:
				if (req.valid)
					state_nxt = axil2apb_pkg::S_SETUP;
			axil2apb_pkg::S_SETUP:
				state_nxt = axil2apb_pkg::S_ACCESS;
			// Wait out slave wait states
			axil2apb_pkg::S_ACCESS:
				if (i_pready)
					state_nxt = axil2apb_pkg::S_IDLE;
			default:
				state_nxt = axil2apb_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			state <= axil2apb_pkg::S_IDLE;
		else
			state <= state_nxt;
	end

	// Bus phase straight from the state register
	assign o_psel    = (state != axil2apb_pkg::S_IDLE);
	assign o_penable = (state == axil2apb_pkg::S_ACCESS);

	// Latch the request, word aligned address
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (req.valid && req.ready)
		begin
			o_paddr  <= {req.addr, {axil2apb_pkg::ADDR_LSB{1'b0}}};
			o_pwrite <= req.write;
			o_pprot  <= req.prot;
			o_pwdata <= req.wdata;
			o_pwstrb <= req.wstrb;
		end
	end

	// Completion pulse on the PREADY cycle
	assign done.done  = (state == axil2apb_pkg::S_ACCESS) && i_pready;
	assign done.write = o_pwrite;
	assign done.rdata = i_prdata;
	assign done.error = i_pslverr;

endmodule

// File: hw/axil_response.sv
// AXI-lite B and R output registers, holding each completion until it is taken
`timescale 1ns/1ps

module axil_response (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	apb_done_if.response          done,
	// Write response channel
	output logic                  o_bvalid,
	input  logic                  i_bready,
	output axil2apb_pkg::resp_t   o_bresp,
	// Read data channel
	output logic                  o_rvalid,
	input  logic                  i_rready,
	output axil2apb_pkg::data_t   o_rdata,
	output axil2apb_pkg::resp_t   o_rresp
);

	axil2apb_pkg::resp_t done_resp;
	logic                b_load;
	logic                r_load;

	// PSLVERR becomes SLVERR
	assign done_resp = done.error ? axil2apb_pkg::RESP_SLVERR : axil2apb_pkg::RESP_OKAY;
	assign b_load    = done.done && done.write;
	assign r_load    = done.done && !done.write;

	// Slot open when empty or draining now
	assign done.b_free = !o_bvalid || i_bready;
	assign done.r_free = !o_rvalid || i_rready;

////////////////////////////////////////////////////////////////////////////
// B channel
////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_bvalid <= 1'b0;
			o_bresp  <= axil2apb_pkg::RESP_OKAY;
		end
		else if (b_load)
		begin
			o_bvalid <= 1'b1;
			o_bresp  <= done_resp;
		end
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

////////////////////////////////////////////////////////////////////////////
// R channel
////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_rvalid <= 1'b0;
			o_rresp  <= axil2apb_pkg::RESP_OKAY;
		end
		else if (r_load)
		begin
			o_rvalid <= 1'b1;
			o_rresp  <= done_resp;
		end
		else if (i_rready)
			o_rvalid <= 1'b0;
	end

	// Read data, no reset
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (r_load)
			o_rdata <= done.rdata;
	end

endmodule

// File: hw/axil2apb_top.sv
// AXI-lite slave to APB master bridge top level
`timescale 1ns/1ps

module axil2apb_top (
	input  logic                 S_AXI_ACLK,
	input  logic                 S_AXI_ARESETN,
	// AXI-lite write address
	input  logic                 S_AXI_AWVALID,
	output logic                 S_AXI_AWREADY,
	input  axil2apb_pkg::addr_t  S_AXI_AWADDR,
	input  axil2apb_pkg::prot_t  S_AXI_AWPROT,
	// AXI-lite write data
	input  logic                 S_AXI_WVALID,
	output logic                 S_AXI_WREADY,
	input  axil2apb_pkg::data_t  S_AXI_WDATA,
	input  axil2apb_pkg::strb_t  S_AXI_WSTRB,
	// AXI-lite write response
	output logic                 S_AXI_BVALID,
	input  logic                 S_AXI_BREADY,
	output axil2apb_pkg::resp_t  S_AXI_BRESP,
	// AXI-lite read address
	input  logic                 S_AXI_ARVALID,
	output logic                 S_AXI_ARREADY,
	input  axil2apb_pkg::addr_t  S_AXI_ARADDR,
	input  axil2apb_pkg::prot_t  S_AXI_ARPROT,
	// AXI-lite read data
	output logic                 S_AXI_RVALID,
	input  logic                 S_AXI_RREADY,
	output axil2apb_pkg::data_t  S_AXI_RDATA,
	output axil2apb_pkg::resp_t  S_AXI_RRESP,
	// APB master
	output logic                 M_APB_PSEL,
	output logic                 M_APB_PENABLE,
	input  logic                 M_APB_PREADY,
	output axil2apb_pkg::addr_t  M_APB_PADDR,
	output logic                 M_APB_PWRITE,
	output axil2apb_pkg::data_t  M_APB_PWDATA,
	output axil2apb_pkg::strb_t  M_APB_PWSTRB,
	output axil2apb_pkg::prot_t  M_APB_PPROT,
	input  axil2apb_pkg::data_t  M_APB_PRDATA,
	input  logic                 M_APB_PSLVERR
);

	// Skid buffer outputs toward the arbiter
	logic aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
	axil2apb_pkg::waddr_t aw_addr;
	axil2apb_pkg::waddr_t ar_addr;
	axil2apb_pkg::prot_t  aw_prot;
	axil2apb_pkg::prot_t  ar_prot;
	axil2apb_pkg::data_t  w_data;
	axil2apb_pkg::strb_t  w_strb;

	apb_req_if  req_bus ();
	apb_done_if done_bus ();

////////////////////////////////////////////////////////////////////////////
// Incoming channels, byte offset dropped on entry
////////////////////////////////////////////////////////////////////////////
	skid_buffer #(
		.WIDTH(axil2apb_pkg::ADDR_W - axil2apb_pkg::ADDR_LSB + axil2apb_pkg::PROT_W)
	) aw_skid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(S_AXI_AWVALID), .o_ready(S_AXI_AWREADY),
		.i_data({S_AXI_AWADDR[axil2apb_pkg::ADDR_W-1:axil2apb_pkg::ADDR_LSB], S_AXI_AWPROT}),
		.o_valid(aw_valid), .i_ready(aw_ready), .o_data({aw_addr, aw_prot})
	);

	skid_buffer #(
		.WIDTH(axil2apb_pkg::DATA_W + axil2apb_pkg::STRB_W)
	) w_skid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(S_AXI_WVALID), .o_ready(S_AXI_WREADY),
		.i_data({S_AXI_WDATA, S_AXI_WSTRB}),
		.o_valid(w_valid), .i_ready(w_ready), .o_data({w_data, w_strb})
	);

	skid_buffer #(
		.WIDTH(axil2apb_pkg::ADDR_W - axil2apb_pkg::ADDR_LSB + axil2apb_pkg::PROT_W)
	) ar_skid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(S_AXI_ARVALID), .o_ready(S_AXI_ARREADY),
		.i_data({S_AXI_ARADDR[axil2apb_pkg::ADDR_W-1:axil2apb_pkg::ADDR_LSB], S_AXI_ARPROT}),
		.o_valid(ar_valid), .i_ready(ar_ready), .o_data({ar_addr, ar_prot})
	);

////////////////////////////////////////////////////////////////////////////
// Arbitration, APB sequencing, responses
////////////////////////////////////////////////////////////////////////////
	req_arbiter u_arbiter (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_aw_valid(aw_valid), .o_aw_ready(aw_ready),
		.i_aw_addr(aw_addr), .i_aw_prot(aw_prot),
		.i_w_valid(w_valid), .o_w_ready(w_ready),
		.i_w_data(w_data), .i_w_strb(w_strb),
		.i_ar_valid(ar_valid), .o_ar_ready(ar_ready),
		.i_ar_addr(ar_addr), .i_ar_prot(ar_prot),
		.req(req_bus.source), .done(done_bus.arbiter)
	);

	apb_sequencer u_sequencer (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.req(req_bus.sink), .done(done_bus.source),
		.o_psel(M_APB_PSEL), .o_penable(M_APB_PENABLE),
		.o_paddr(M_APB_PADDR), .o_pwrite(M_APB_PWRITE),
		.o_pwdata(M_APB_PWDATA), .o_pwstrb(M_APB_PWSTRB), .o_pprot(M_APB_PPROT),
		.i_pready(M_APB_PREADY), .i_prdata(M_APB_PRDATA), .i_pslverr(M_APB_PSLVERR)
	);

	axil_response u_response (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.done(done_bus.response),
		.o_bvalid(S_AXI_BVALID), .i_bready(S_AXI_BREADY), .o_bresp(S_AXI_BRESP),
		.o_rvalid(S_AXI_RVALID), .i_rready(S_AXI_RREADY),
		.o_rdata(S_AXI_RDATA), .o_rresp(S_AXI_RRESP)
	);

endmodule

// File: test/apb_slave_model.sv
// APB slave memory model with random wait states and an error region at address bit 12
`timescale 1ns/1ps

module apb_slave_model (
	input  logic                 S_AXI_ACLK,
	input  logic                 S_AXI_ARESETN,
	input  logic                 i_psel,
	input  logic                 i_penable,
	input  axil2apb_pkg::addr_t  i_paddr,
	input  logic                 i_pwrite,
	input  axil2apb_pkg::data_t  i_pwdata,
	input  axil2apb_pkg::strb_t  i_pwstrb,
	output logic                 o_pready,
	output axil2apb_pkg::data_t  o_prdata,
	output logic                 o_pslverr
);

	// 16 words, indexed by PADDR[5:2]
	axil2apb_pkg::data_t mem [0:15];
	logic [1:0]          wait_cnt;

	assign o_prdata  = mem[i_paddr[5:2]];
	assign o_pslverr = i_paddr[12];

	// Wait states drawn in the setup cycle
	always @(posedge S_AXI_ACLK)
	begin : wait_gen
		logic [1:0] draw;
		if (!S_AXI_ARESETN)
		begin
			o_pready <= 1'b0;
			wait_cnt <= 2'd0;
		end
		else if (i_psel && !i_penable)
		begin
			draw = 2'($urandom_range(3, 0));
			wait_cnt <= draw;
			o_pready <= (draw == 2'd0);
		end
		else if (i_psel && i_penable && !o_pready)
		begin
			wait_cnt <= wait_cnt - 2'd1;
			o_pready <= (wait_cnt == 2'd1);
		end
		else
			o_pready <= 1'b0;
	end

	// Byte-enabled write, error region left untouched
	always @(posedge S_AXI_ACLK)
	begin
		if (i_psel && i_penable && o_pready && i_pwrite && !i_paddr[12])
			for (int b = 0; b < 4; b++)
				if (i_pwstrb[b])
					mem[i_paddr[5:2]][8*b +: 8] <= i_pwdata[8*b +: 8];
	end

endmodule

// File: test/tb_axil2apb.sv
// Testbench for the AXI-lite to APB bridge, driven from a stimulus file
`timescale 1ns/1ps

module tb_axil2apb;

	localparam int STIM_WORDS = 256;
	localparam int TIMEOUT    = 200;

	logic                 S_AXI_ACLK, S_AXI_ARESETN;
	logic                 S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
	axil2apb_pkg::addr_t  S_AXI_AWADDR, S_AXI_ARADDR, M_APB_PADDR;
	axil2apb_pkg::prot_t  S_AXI_AWPROT, S_AXI_ARPROT, M_APB_PPROT;
	axil2apb_pkg::data_t  S_AXI_WDATA, S_AXI_RDATA, M_APB_PWDATA, M_APB_PRDATA;
	axil2apb_pkg::strb_t  S_AXI_WSTRB, M_APB_PWSTRB;
	logic                 S_AXI_BVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_ARREADY;
	logic                 S_AXI_RVALID, S_AXI_RREADY;
	axil2apb_pkg::resp_t  S_AXI_BRESP, S_AXI_RRESP;
	logic                 M_APB_PSEL, M_APB_PENABLE, M_APB_PREADY, M_APB_PWRITE, M_APB_PSLVERR;

	logic [31:0] stim [0:STIM_WORDS-1];
	// PWRITE of each finished APB transfer, in order
	bit          apb_order [$];
	int          b_seen, r_seen;

	always #5 S_AXI_ACLK = ~S_AXI_ACLK;

	axil2apb_top i_dut (.*);

	apb_slave_model u_slave (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_psel(M_APB_PSEL), .i_penable(M_APB_PENABLE), .i_paddr(M_APB_PADDR),
		.i_pwrite(M_APB_PWRITE), .i_pwdata(M_APB_PWDATA), .i_pwstrb(M_APB_PWSTRB),
		.o_pready(M_APB_PREADY), .o_prdata(M_APB_PRDATA), .o_pslverr(M_APB_PSLVERR)
	);

////////////////////////////////////////////////////////////////////////////
// Monitor, sampled mid-cycle
////////////////////////////////////////////////////////////////////////////
	always @(negedge S_AXI_ACLK)
	begin
		if (S_AXI_BVALID && S_AXI_BREADY)
			b_seen++;
		if (S_AXI_RVALID && S_AXI_RREADY)
			r_seen++;
		if (M_APB_PSEL && M_APB_PENABLE && M_APB_PREADY)
		begin
			apb_order.push_back(M_APB_PWRITE);
			// Word-aligned address and protection of the AXI request
			check("PADDR", M_APB_PADDR,
				(M_APB_PWRITE ? S_AXI_AWADDR : S_AXI_ARADDR) & ~32'h3);
			check("PPROT", 32'(M_APB_PPROT),
				32'(M_APB_PWRITE ? S_AXI_AWPROT : S_AXI_ARPROT));
		end
	end

	task automatic fail_run(input string why);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Error: %0t ns: %s is %h, expected %h", $time, what, got, exp);
			fail_run({what, " mismatch"});
		end
	endtask

	// AW or AR address phase
	task automatic send_addr(input bit rd, input axil2apb_pkg::addr_t addr);
		int                  n;
		axil2apb_pkg::prot_t prot;
		n    = 0;
		prot = axil2apb_pkg::prot_t'($urandom_range(7, 0));
		@(posedge S_AXI_ACLK);
		if (rd)
		begin
			S_AXI_ARVALID <= 1'b1;
			S_AXI_ARADDR  <= addr;
			S_AXI_ARPROT  <= prot;
		end
		else
		begin
			S_AXI_AWVALID <= 1'b1;
			S_AXI_AWADDR  <= addr;
			S_AXI_AWPROT  <= prot;
		end
		@(negedge S_AXI_ACLK);
		while (!(rd ? S_AXI_ARREADY : S_AXI_AWREADY))
		begin
			n++;
			if (n > TIMEOUT)
				fail_run("Timeout: address channel never became ready");
			@(negedge S_AXI_ACLK);
		end
		@(posedge S_AXI_ACLK);
		if (rd)
			S_AXI_ARVALID <= 1'b0;
		else
			S_AXI_AWVALID <= 1'b0;
	endtask

	task automatic send_w(input axil2apb_pkg::data_t data, input axil2apb_pkg::strb_t strb);
		int n;
		n = 0;
		@(posedge S_AXI_ACLK);
		S_AXI_WVALID <= 1'b1;
		S_AXI_WDATA  <= data;
		S_AXI_WSTRB  <= strb;
		@(negedge S_AXI_ACLK);
		while (!S_AXI_WREADY)
		begin
			n++;
			if (n > TIMEOUT)
				fail_run("Timeout: write data channel never became ready");
			@(negedge S_AXI_ACLK);
		end
		@(posedge S_AXI_ACLK);
		S_AXI_WVALID <= 1'b0;
	endtask

	// Wait for B, stall a random while, then take it
	task automatic take_b(input axil2apb_pkg::resp_t exp);
		int                  n;
		int                  stall;
		axil2apb_pkg::resp_t held;
		n = 0;
		@(negedge S_AXI_ACLK);
		while (!S_AXI_BVALID)
		begin
			n++;
			if (n > TIMEOUT)
				fail_run("Timeout: no write response arrived");
			@(negedge S_AXI_ACLK);
		end
		held  = S_AXI_BRESP;
		stall = $urandom_range(3, 0);
		repeat (stall)
		begin
			@(negedge S_AXI_ACLK);
			check("BVALID while stalled", 32'(S_AXI_BVALID), 32'd1);
			check("BRESP while stalled", 32'(S_AXI_BRESP), 32'(held));
		end
		@(posedge S_AXI_ACLK);
		S_AXI_BREADY <= 1'b1;
		// Response as the master takes it
		@(negedge S_AXI_ACLK);
		check("BVALID at handshake", 32'(S_AXI_BVALID), 32'd1);
		check("BRESP", 32'(S_AXI_BRESP), 32'(exp));
		@(posedge S_AXI_ACLK);
		S_AXI_BREADY <= 1'b0;
	endtask

	task automatic take_r(input axil2apb_pkg::resp_t exp, input axil2apb_pkg::data_t exp_data);
		int                  n;
		int                  stall;
		axil2apb_pkg::resp_t held;
		axil2apb_pkg::data_t held_data;
		n = 0;
		@(negedge S_AXI_ACLK);
		while (!S_AXI_RVALID)
		begin
			n++;
			if (n > TIMEOUT)
				fail_run("Timeout: no read response arrived");
			@(negedge S_AXI_ACLK);
		end
		held      = S_AXI_RRESP;
		held_data = S_AXI_RDATA;
		stall     = $urandom_range(3, 0);
		repeat (stall)
		begin
			@(negedge S_AXI_ACLK);
			check("RVALID while stalled", 32'(S_AXI_RVALID), 32'd1);
			check("RRESP while stalled", 32'(S_AXI_RRESP), 32'(held));
			check("RDATA while stalled", S_AXI_RDATA, held_data);
		end
		@(posedge S_AXI_ACLK);
		S_AXI_RREADY <= 1'b1;
		// Response as the master takes it
		@(negedge S_AXI_ACLK);
		check("RVALID at handshake", 32'(S_AXI_RVALID), 32'd1);
		check("RRESP", 32'(S_AXI_RRESP), 32'(exp));
		// Error reads carry no meaningful data
		if (exp == axil2apb_pkg::RESP_OKAY)
			check("RDATA", S_AXI_RDATA, exp_data);
		@(posedge S_AXI_ACLK);
		S_AXI_RREADY <= 1'b0;
	endtask

////////////////////////////////////////////////////////////////////////////
// Main sequence
////////////////////////////////////////////////////////////////////////////
	initial
	begin : main
		int idx;
		int exp_b;
		int exp_r;
		void'($urandom(32'h2a5f));
		S_AXI_ACLK    = 1'b0;
		S_AXI_ARESETN = 1'b0;
		S_AXI_AWVALID = 1'b0;
		S_AXI_AWADDR  = '0;
		S_AXI_AWPROT  = '0;
		S_AXI_WVALID  = 1'b0;
		S_AXI_WDATA   = '0;
		S_AXI_WSTRB   = '0;
		S_AXI_BREADY  = 1'b0;
		S_AXI_ARVALID = 1'b0;
		S_AXI_ARADDR  = '0;
		S_AXI_ARPROT  = '0;
		S_AXI_RREADY  = 1'b0;
		b_seen = 0;
		r_seen = 0;
		idx    = 0;
		exp_b  = 0;
		exp_r  = 0;
		$readmemh("test/axil2apb_stimulus.txt", stim);
		repeat (8) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;

		// Idle bus straight out of reset
		@(negedge S_AXI_ACLK);
		check("PSEL after reset", 32'(M_APB_PSEL), 32'd0);
		check("PENABLE after reset", 32'(M_APB_PENABLE), 32'd0);
		check("BVALID after reset", 32'(S_AXI_BVALID), 32'd0);
		check("RVALID after reset", 32'(S_AXI_RVALID), 32'd0);

		while (stim[idx] !== 32'hf)
		begin
			if (idx + 12 > STIM_WORDS)
				fail_run("Stimulus file has no end marker");
			case (stim[idx])
				32'd0:
				begin
					fork
						send_addr(1'b0, stim[idx+1]);
						send_w(stim[idx+2], 4'(stim[idx+3]));
					join
					take_b(2'(stim[idx+4]));
					exp_b++;
					idx += 6;
				end
				32'd1:
				begin
					send_addr(1'b1, stim[idx+1]);
					take_r(2'(stim[idx+4]), stim[idx+5]);
					exp_r++;
					idx += 6;
				end
				// Write and the next line's read issued in the same cycle
				32'd2:
				begin
					apb_order.delete();
					fork
						send_addr(1'b0, stim[idx+1]);
						send_w(stim[idx+2], 4'(stim[idx+3]));
						send_addr(1'b1, stim[idx+7]);
					join
					fork
						take_b(2'(stim[idx+4]));
						take_r(2'(stim[idx+10]), stim[idx+11]);
					join
					check("APB transfers in pair", 32'(apb_order.size()), 32'd2);
					check("First PWRITE of pair", 32'(apb_order[0]), 32'd0);
					check("Second PWRITE of pair", 32'(apb_order[1]), 32'd1);
					exp_b++;
					exp_r++;
					idx += 12;
				end
				default:
					fail_run("Unknown operation code in stimulus file");
			endcase
		end

		// Settle, so that a duplicate response would show up
		repeat (4) @(negedge S_AXI_ACLK);
		if (b_seen == exp_b && r_seen == exp_r && !S_AXI_BVALID && !S_AXI_RVALID)
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
		else
			fail_run("Number of responses does not match the stimulus lines");
	end

endmodule

// File: files.f
hw/axil2apb_pkg.sv
hw/bridge_if.sv
hw/skid_buffer.sv
hw/req_arbiter.sv
hw/apb_sequencer.sv
hw/axil_response.sv
hw/axil2apb_top.sv
test/apb_slave_model.sv
test/tb_axil2apb.sv

// File: Makefile
# Verilator simulation of the AXI-lite to APB bridge

VERILATOR ?= verilator
TOP       ?= tb_axil2apb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: test/axil2apb_stimulus.txt
// op addr data strb resp rdata (hex)
// op 0 write, 1 read, 2 write sent with the read on the next line, f end
0 00000000 11111111 f 0 00000000
0 00000004 22222222 f 0 00000000
0 00000008 33333333 f 0 00000000
0 0000000c 44444444 f 0 00000000
1 00000000 00000000 0 0 11111111
1 00000007 00000000 0 0 22222222
1 0000000a 00000000 0 0 33333333
1 0000000d 00000000 0 0 44444444
0 00000010 aabbccdd f 0 00000000
0 00000010 00ee0011 5 0 00000000
1 00000010 00000000 0 0 aaeecc11
0 00001004 deadbeef f 2 00000000
1 00001008 00000000 0 2 00000000
1 00000004 00000000 0 0 22222222
0 00000014 55555555 f 0 00000000
2 00000018 66666666 f 0 00000000
1 00000004 00000000 0 0 22222222
0 0000001c 77777777 f 0 00000000
2 00000020 88888888 f 0 00000000
1 00000018 00000000 0 0 66666666
1 00000020 00000000 0 0 88888888
f 00000000 00000000 0 0 00000000
